//--- tage_pkg.sv
package tage_pkg;

    // Branch address and global history.
    localparam int pc_w = 16;
    localparam int ghist_len = 16;

    // Every table has the same number of entries.
    localparam int index_len = 6;
    localparam int num_entries = 1 << index_len;

    localparam int tag_len = 8;
    localparam int ctr_len = 3;     // Signed, -4 to 3.
    localparam int useful_len = 2;

    // History lengths of the two tagged components.
    localparam int hist_len_short = 4;
    localparam int hist_len_long = 16;

    typedef logic [pc_w-1:0] pc_t;

    typedef logic [1:0] provider_t;

    localparam provider_t prov_base = 2'd0;
    localparam provider_t prov_short = 2'd1;
    localparam provider_t prov_long = 2'd2;

    // Result of a lookup in one tagged component.
    typedef struct packed {
        logic                          hit;
        logic signed [ctr_len-1:0]     ctr;
        logic        [useful_len-1:0]  useful;
    } comp_read_t;

    // Write strobes from the selection block to one tagged component.
    typedef struct packed {
        logic upd_ctr;
        logic allocate;
        logic inc_useful;
        logic dec_useful;
    } comp_write_t;

endpackage

//--- global_history.sv
`timescale 1ns/100ps

module global_history (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           branch_valid,
    input  logic                           branch_taken,
    output logic [tage_pkg::ghist_len-1:0] ghist
);
    import tage_pkg::*;

    // Bit 0 holds the youngest resolved outcome.
    always_ff @(posedge clk) begin
        if (rst) begin
            ghist <= '0;
        end else if (branch_valid) begin
            ghist <= {ghist[ghist_len-2:0], branch_taken};
        end
    end

endmodule

//--- base_predictor.sv
`timescale 1ns/100ps

module base_predictor (
    input  logic          clk,
    input  logic          rst,
    input  tage_pkg::pc_t branch_pc,
    input  logic          base_upd,
    input  logic          branch_taken,
    output logic [1:0]    base_ctr
);
    import tage_pkg::*;

    logic [1:0]           ctr_mem [num_entries];
    logic [index_len-1:0] idx;

    // Bits 1:0 of a branch address carry no information.
    assign idx = branch_pc[index_len+1:2];

    assign base_ctr = ctr_mem[idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_entries; i++) begin
                ctr_mem[i] <= 2'b10;  // Weakly taken.
            end
        end else if (base_upd) begin
            if (branch_taken && ctr_mem[idx] != 2'b11) begin
                ctr_mem[idx] <= ctr_mem[idx] + 2'd1;
            end else if (!branch_taken && ctr_mem[idx] != 2'b00) begin
                ctr_mem[idx] <= ctr_mem[idx] - 2'd1;
            end
        end
    end

endmodule

//--- tage_component.sv
`timescale 1ns/100ps

module tage_component #(
    parameter int hist_len = tage_pkg::hist_len_short
) (
    input  logic                           clk,
    input  logic                           rst,
    input  tage_pkg::pc_t                  branch_pc,
    input  logic [tage_pkg::ghist_len-1:0] ghist,
    input  tage_pkg::comp_write_t          write,
    input  logic                           branch_taken,
    output tage_pkg::comp_read_t           read
);
    import tage_pkg::*;

    logic [ctr_len-1:0]    ctr_mem    [num_entries];
    logic [useful_len-1:0] useful_mem [num_entries];
    logic [tag_len-1:0]    tag_mem    [num_entries];
    logic [num_entries-1:0] valid;

    logic [index_len-1:0] idx_fold;
    logic [tag_len-2:0]   tag_fold;
    logic [index_len-1:0] idx;
    logic [tag_len-1:0]   tag;

    // The tag fold is one bit narrower than the tag, so it does not alias with
    // the index fold on periodic histories.
    always_comb begin
        idx_fold = '0;
        tag_fold = '0;
        for (int i = 0; i < hist_len; i++) begin
            idx_fold[i % index_len] = idx_fold[i % index_len] ^ ghist[i];
            tag_fold[i % (tag_len-1)] = tag_fold[i % (tag_len-1)] ^ ghist[i];
        end
    end

    assign idx = idx_fold ^ branch_pc[index_len+1:2];
    assign tag = branch_pc[pc_w-1 -: tag_len] ^ {tag_fold, 1'b0};  // Fold shifted up one bit.

    always_comb begin
        read.hit = valid[idx] && (tag_mem[idx] == tag);
        read.ctr = ctr_mem[idx];
        read.useful = useful_mem[idx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            for (int i = 0; i < num_entries; i++) begin
                ctr_mem[i] <= '0;
                useful_mem[i] <= '0;
            end
        end else if (write.allocate) begin
            valid[idx] <= 1'b1;
            useful_mem[idx] <= '0;
            // Weak counter in the direction of the outcome, 0 or -1.
            ctr_mem[idx] <= branch_taken ? '0 : '1;
        end else begin
            if (write.upd_ctr) begin
                if (branch_taken && ctr_mem[idx] != {1'b0, {(ctr_len-1){1'b1}}}) begin
                    ctr_mem[idx] <= ctr_mem[idx] + 1'b1;
                end else if (!branch_taken && ctr_mem[idx] != {1'b1, {(ctr_len-1){1'b0}}}) begin
                    ctr_mem[idx] <= ctr_mem[idx] - 1'b1;
                end
            end
            if (write.inc_useful && useful_mem[idx] != {useful_len{1'b1}}) begin
                useful_mem[idx] <= useful_mem[idx] + 1'b1;
            end else if (write.dec_useful && useful_mem[idx] != '0) begin
                useful_mem[idx] <= useful_mem[idx] - 1'b1;
            end
        end
    end

    // The tag of an entry is written on every allocation.
    always_ff @(posedge clk) begin
        if (write.allocate) begin
            tag_mem[idx] <= tag;
        end
    end

endmodule

//--- tage_select.sv
`timescale 1ns/100ps

module tage_select (
    input  logic                  branch_valid,
    input  logic                  branch_taken,
    input  tage_pkg::comp_read_t  read_short,
    input  tage_pkg::comp_read_t  read_long,
    input  logic [1:0]            base_ctr,
    output logic                  pred_taken,
    output tage_pkg::provider_t   pred_provider,
    output tage_pkg::comp_write_t write_short,
    output tage_pkg::comp_write_t write_long,
    output logic                  base_upd
);
    import tage_pkg::*;

    logic pred_base;
    logic pred_short;
    logic pred_long;
    logic alt_pred;
    logic mispredict;
    logic alt_differs;

    assign pred_base = base_ctr[1];
    assign pred_short = ~read_short.ctr[ctr_len-1];  // Non-negative means taken.
    assign pred_long = ~read_long.ctr[ctr_len-1];

    // The longest hitting component provides. The alternate is the next hit below it.
    always_comb begin
        if (read_long.hit) begin
            pred_provider = prov_long;
            pred_taken = pred_long;
            alt_pred = read_short.hit ? pred_short : pred_base;
        end else if (read_short.hit) begin
            pred_provider = prov_short;
            pred_taken = pred_short;
            alt_pred = pred_base;
        end else begin
            pred_provider = prov_base;
            pred_taken = pred_base;
            alt_pred = pred_base;
        end
    end

    assign mispredict = pred_taken != branch_taken;
    assign alt_differs = pred_taken != alt_pred;

    always_comb begin
        write_short = '0;
        write_long = '0;
        base_upd = 1'b0;
        if (branch_valid) begin
            case (pred_provider)
                prov_long: begin
                    write_long.upd_ctr = 1'b1;
                    write_long.inc_useful = alt_differs && !mispredict;
                    write_long.dec_useful = alt_differs && mispredict;
                end
                prov_short: begin
                    write_short.upd_ctr = 1'b1;
                    write_short.inc_useful = alt_differs && !mispredict;
                    write_short.dec_useful = alt_differs && mispredict;
                    if (mispredict) begin
                        if (read_long.useful == '0) begin
                            write_long.allocate = 1'b1;
                        end else begin
                            write_long.dec_useful = 1'b1;  // No free entry, age it instead.
                        end
                    end
                end
                default: begin
                    base_upd = 1'b1;
                    if (mispredict) begin
                        // Take the shortest component that has a free entry.
                        if (read_short.useful == '0) begin
                            write_short.allocate = 1'b1;
                        end else if (read_long.useful == '0) begin
                            write_long.allocate = 1'b1;
                        end else begin
                            write_short.dec_useful = 1'b1;
                            write_long.dec_useful = 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- tage_predictor.sv
`timescale 1ns/100ps

module tage_predictor (
    input  logic                clk,
    input  logic                rst,
    input  logic                branch_valid,
    input  tage_pkg::pc_t       branch_pc,
    input  logic                branch_taken,
    output logic                pred_taken,
    output tage_pkg::provider_t pred_provider
);
    import tage_pkg::*;

    logic [ghist_len-1:0] ghist;
    logic [1:0]           base_ctr;
    logic                 base_upd;
    comp_read_t           read_short;
    comp_read_t           read_long;
    comp_write_t          write_short;
    comp_write_t          write_long;

    global_history global_history_i (
        .clk          (clk),
        .rst          (rst),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .ghist        (ghist)
    );

    base_predictor base_predictor_i (
        .clk          (clk),
        .rst          (rst),
        .branch_pc    (branch_pc),
        .base_upd     (base_upd),
        .branch_taken (branch_taken),
        .base_ctr     (base_ctr)
    );

    tage_component #(
        .hist_len (hist_len_short)
    ) comp_short (
        .clk          (clk),
        .rst          (rst),
        .branch_pc    (branch_pc),
        .ghist        (ghist),
        .write        (write_short),
        .branch_taken (branch_taken),
        .read         (read_short)
    );

    tage_component #(
        .hist_len (hist_len_long)
    ) comp_long (
        .clk          (clk),
        .rst          (rst),
        .branch_pc    (branch_pc),
        .ghist        (ghist),
        .write        (write_long),
        .branch_taken (branch_taken),
        .read         (read_long)
    );

    tage_select tage_select_i (
        .branch_valid  (branch_valid),
        .branch_taken  (branch_taken),
        .read_short    (read_short),
        .read_long     (read_long),
        .base_ctr      (base_ctr),
        .pred_taken    (pred_taken),
        .pred_provider (pred_provider),
        .write_short   (write_short),
        .write_long    (write_long),
        .base_upd      (base_upd)
    );

endmodule

//--- tage_predictor_checker.sv
`timescale 1ns/100ps

module tage_predictor_checker (
    input logic                clk,
    input logic                rst,
    input logic                branch_valid,
    input logic                branch_taken,
    input logic                pred_taken,
    input tage_pkg::provider_t pred_provider
);
    import tage_pkg::*;

    int   fail_count = 0;
    logic seen_mispredict;

    // Entries are only allocated on a misprediction. Before one, no tagged table can provide.
    always_ff @(posedge clk) begin
        if (rst) begin
            seen_mispredict <= 1'b0;
        end else if (branch_valid && pred_taken != branch_taken) begin
            seen_mispredict <= 1'b1;
        end
    end

    provider_legal: assert property (
        @(posedge clk) disable iff (rst) pred_provider != 2'd3
    ) else begin
        fail_count++;
        $error("pred_provider took the unused code 3.");
    end

    outputs_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown({pred_taken, pred_provider})
    ) else begin
        fail_count++;
        $error("pred_taken or pred_provider is unknown after reset.");
    end

    tagged_after_mispredict: assert property (
        @(posedge clk) disable iff (rst) (pred_provider != prov_base) |-> seen_mispredict
    ) else begin
        fail_count++;
        $error("A tagged table provided before any mispredicted branch since reset.");
    end

endmodule

//--- tb_tage_predictor.sv
`timescale 1ns/100ps

module tb_tage_predictor;
    import tage_pkg::*;

    localparam int max_cycles = 5000;
    localparam int settle_tries = 3;

    logic      clk = 1'b0;
    logic      rst;
    logic      branch_valid;
    pc_t       branch_pc;
    logic      branch_taken;
    logic      pred_taken;
    provider_t pred_provider;

    int seed;
    int cycle_count = 0;

    tage_predictor tage_predictor_i (
        .clk           (clk),
        .rst           (rst),
        .branch_valid  (branch_valid),
        .branch_pc     (branch_pc),
        .branch_taken  (branch_taken),
        .pred_taken    (pred_taken),
        .pred_provider (pred_provider)
    );

    bind tage_predictor tage_predictor_checker bound_checks_i (
        .clk           (clk),
        .rst           (rst),
        .branch_valid  (branch_valid),
        .branch_taken  (branch_taken),
        .pred_taken    (pred_taken),
        .pred_provider (pred_provider)
    );

    always #2 clk = ~clk;

    task automatic stop_failed();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("The run did not finish within %0d clock cycles.", max_cycles);
            stop_failed();
        end
    end

    always @(negedge clk) begin
        if (tage_predictor_i.bound_checks_i.fail_count != 0) begin
            $display("A concurrent assertion of the bound checker failed.");
            stop_failed();
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        #0.5;
        rst = 1'b1;
        branch_valid = 1'b0;
        repeat (4) @(posedge clk);
        #0.5;
        rst = 1'b0;
    endtask

    // Drives one lookup and returns where the combinational prediction has settled.
    task automatic drive_branch(input logic valid, input pc_t pc, input logic taken);
        @(posedge clk);
        #0.5;
        branch_valid = valid;
        branch_pc = pc;
        branch_taken = taken;
        @(negedge clk);
    endtask

    task automatic expect_taken(input string name, input logic expected);
        assert (pred_taken === expected) else begin
            $display("[ERROR] %s: expected pred_taken %0d, actual %0d",
                     name, expected, pred_taken);
            stop_failed();
        end
    endtask

    task automatic expect_provider(input string name, input provider_t expected);
        assert (pred_provider === expected) else begin
            $display("[ERROR] %s: expected pred_provider %0d, actual %0d",
                     name, expected, pred_provider);
            stop_failed();
        end
    endtask

    task automatic expect_tagged(input string name);
        assert (pred_provider === prov_short || pred_provider === prov_long) else begin
            $display("[ERROR] %s: expected pred_provider 1 or 2, actual %0d",
                     name, pred_provider);
            stop_failed();
        end
    endtask

    // With no valid entry, base decides and every base counter is weakly taken.
    task automatic check_cold_lookups(input string name);
        for (int i = 0; i < 16; i++) begin
            drive_branch(1'b0, pc_t'($random(seed)), 1'b0);
            expect_taken(name, 1'b1);
            expect_provider(name, prov_base);
        end
    endtask

    task automatic run_never_taken(input pc_t pc);
        logic settled;
        repeat (16) drive_branch(1'b1, pc, 1'b0);
        settled = 1'b0;
        for (int n = 0; n < settle_tries && !settled; n++) begin
            drive_branch(1'b1, pc, 1'b0);
            settled = !pred_taken;
        end
        if (!settled) begin
            $display("The never-taken branch was still predicted taken after %0d occurrences.",
                     16 + settle_tries);
            stop_failed();
        end
        for (int n = 0; n < 20; n++) begin
            drive_branch(1'b1, pc, 1'b0);
            expect_taken("never_taken", 1'b0);
        end
    endtask

    // Base alone always predicts taken here, so a not-taken hit must come from a tagged table.
    task automatic run_pattern(input string name, input pc_t pc, input int period,
                               input int warmup, input logic long_only);
        logic outcome;
        for (int i = 0; i < warmup + 40; i++) begin
            outcome = (i % period) != (period - 1);
            drive_branch(1'b1, pc, outcome);
            if (i >= warmup) begin
                expect_taken(name, outcome);
                if (!outcome && long_only) begin
                    expect_provider(name, prov_long);
                end else if (!outcome) begin
                    expect_tagged(name);
                end
            end
        end
    endtask

    task automatic run_random(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            drive_branch(r[3:2] != 2'b00, r[31:16], r[0]);
        end
    endtask

    initial begin
        seed = 32'h6e01_0c07;
        rst = 1'b1;
        branch_valid = 1'b0;
        branch_pc = '0;
        branch_taken = 1'b0;
        apply_reset();
        check_cold_lookups("cold_start");
        run_never_taken(16'h1234);
        apply_reset();
        run_pattern("period_4", 16'h4a3c, 4, 200, 1'b0);
        apply_reset();
        run_pattern("period_8", 16'hb2d0, 8, 400, 1'b1);
        run_random(60);
        apply_reset();
        check_cold_lookups("mid_run_reset");
        run_random(300);
        drive_branch(1'b0, '0, 1'b0);  // Lets the checker sample the last branch.
        if (tage_predictor_i.bound_checks_i.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("The bound checker reported %0d assertion failures.",
                     tage_predictor_i.bound_checks_i.fail_count);
            stop_failed();
        end
    end

endmodule

//--- files.f
tage_pkg.sv
global_history.sv
base_predictor.sv
tage_component.sv
tage_select.sv
tage_predictor.sv
tage_predictor_checker.sv
tb_tage_predictor.sv

//--- Makefile
# Verilator build and run of the TAGE predictor testbench.

VERILATOR ?= verilator
TOP       ?= tb_tage_predictor
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	-./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "^Simulation PASSED$$" $(LOG); then \
		echo "Run passed."; \
	else \
		echo "Run failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
